// File: src/mem_pkg.sv
// memory stage shared definitions
`default_nettype none

package mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [7:0]  aluop_t;
    typedef logic [3:0]  sel_t;
    typedef logic [4:0]  cp0_addr_t;

    // memory operation codes
    localparam aluop_t OP_LB  = 8'b1110_0000;
    localparam aluop_t OP_LH  = 8'b1110_0001;
    localparam aluop_t OP_LW  = 8'b1110_0011;
    localparam aluop_t OP_LBU = 8'b1110_0100;
    localparam aluop_t OP_LHU = 8'b1110_0101;
    localparam aluop_t OP_SB  = 8'b1110_1000;
    localparam aluop_t OP_SH  = 8'b1110_1001;
    localparam aluop_t OP_SW  = 8'b1110_1011;

    // cp0 register numbers
    localparam cp0_addr_t CP0_STATUS = 5'd12;
    localparam cp0_addr_t CP0_CAUSE  = 5'd13;
    localparam cp0_addr_t CP0_EPC    = 5'd14;

    // IP[1:0], WP and IV are the only software-writable cause bits
    localparam word_t CAUSE_WMASK = 32'h00c0_0300;

    // bit positions in the incoming exception vector
    localparam int SYSCALL_IDX     = 8;
    localparam int INSTINVALID_IDX = 9;
    localparam int TRAP_IDX        = 10;
    localparam int OVERFLOW_IDX    = 11;
    localparam int ERET_IDX        = 12;
    localparam int ADEL_IDX        = 13;
    localparam int ADES_IDX        = 14;
    localparam int BREAK_IDX       = 15;

    // resolved exception codes
    localparam word_t EXC_NONE = 32'h0000_0000;
    localparam word_t EXC_INT  = 32'h0000_0001;
    localparam word_t EXC_ADEL = 32'h0000_0004;
    localparam word_t EXC_ADES = 32'h0000_0005;
    localparam word_t EXC_SYS  = 32'h0000_0008;
    localparam word_t EXC_BP   = 32'h0000_0009;
    localparam word_t EXC_RI   = 32'h0000_000a;
    localparam word_t EXC_OV   = 32'h0000_000c;
    localparam word_t EXC_TR   = 32'h0000_000d;
    localparam word_t EXC_ERET = 32'h0000_000e;

    // latest cp0 values as seen by this stage
    typedef struct packed {
        word_t status;
        word_t cause;
        word_t epc;
    } cp0_view_t;

endpackage

`default_nettype wire

// File: src/result_if.sv
// stage result bundle
`timescale 1ns/1ps
`default_nettype none

interface result_if;
    import mem_pkg::*;

    reg_addr_t wd;
    logic      wreg;
    word_t     wdata;
    word_t     exc_code;

    modport lsu (output wd, output wreg, output wdata);
    modport exc (output exc_code);
    modport wb  (input wd, input wreg, input wdata, input exc_code);

endinterface

`default_nettype wire

// File: src/cp0_forward.sv
// cp0 register forwarding
`timescale 1ns/1ps
`default_nettype none

module cp0_forward (
    input  wire                logic wb_cp0_we_i,
    input  mem_pkg::cp0_addr_t wb_cp0_addr_i,
    input  mem_pkg::word_t     wb_cp0_data_i,
    input  mem_pkg::word_t     cp0_status_i,
    input  mem_pkg::word_t     cp0_cause_i,
    input  mem_pkg::word_t     cp0_epc_i,
    output mem_pkg::cp0_view_t cp0_view_o
);
    import mem_pkg::*;

    logic wr_status;
    logic wr_cause;
    logic wr_epc;

    assign wr_status = wb_cp0_we_i && (wb_cp0_addr_i == CP0_STATUS);
    assign wr_cause  = wb_cp0_we_i && (wb_cp0_addr_i == CP0_CAUSE);
    assign wr_epc    = wb_cp0_we_i && (wb_cp0_addr_i == CP0_EPC);

    always_comb
    begin
        cp0_view_o.status = wr_status ? wb_cp0_data_i : cp0_status_i;
        cp0_view_o.epc    = wr_epc ? wb_cp0_data_i : cp0_epc_i;

        // read-only cause fields always come from cp0
        if (wr_cause)
        begin
            cp0_view_o.cause = (wb_cp0_data_i & CAUSE_WMASK) |
                               (cp0_cause_i & ~CAUSE_WMASK);
        end
        else
        begin
            cp0_view_o.cause = cp0_cause_i;
        end
    end

endmodule

`default_nettype wire

// File: src/except_resolve.sv
// final exception resolution
`timescale 1ns/1ps
`default_nettype none

module except_resolve (
    input  mem_pkg::word_t     excepttype_i,
    input  mem_pkg::word_t     inst_addr_i,
    input  mem_pkg::cp0_view_t cp0_view_i,
    output logic               exc_taken_o,
    result_if.exc              res
);
    import mem_pkg::*;

    logic  int_pending;
    word_t code;

    // unmasked interrupt, not in exception level, globally enabled
    assign int_pending = ((cp0_view_i.cause[15:8] & cp0_view_i.status[15:8]) != 8'h00) &&
                         !cp0_view_i.status[1] &&
                         cp0_view_i.status[0];

    always_comb
    begin
        code = EXC_NONE;
        // a zero address marks a bubble, nothing to report
        if (inst_addr_i != '0)
        begin
            if (int_pending)
                code = EXC_INT;
            else if (excepttype_i[SYSCALL_IDX])
                code = EXC_SYS;
            else if (excepttype_i[BREAK_IDX])
                code = EXC_BP;
            else if (excepttype_i[INSTINVALID_IDX])
                code = EXC_RI;
            else if (excepttype_i[TRAP_IDX])
                code = EXC_TR;
            else if (excepttype_i[OVERFLOW_IDX])
                code = EXC_OV;
            else if (excepttype_i[ADEL_IDX])
                code = EXC_ADEL;
            else if (excepttype_i[ADES_IDX])
                code = EXC_ADES;
            else if (excepttype_i[ERET_IDX])
                code = EXC_ERET;
        end
    end

    assign res.exc_code = code;
    assign exc_taken_o  = (code != EXC_NONE);

endmodule

`default_nettype wire

// File: src/lsu_align.sv
// load/store lane alignment
`timescale 1ns/1ps
`default_nettype none

module lsu_align (
    input  mem_pkg::aluop_t    aluop_i,
    input  mem_pkg::word_t     mem_addr_i,
    input  mem_pkg::word_t     reg2_i,
    input  mem_pkg::reg_addr_t wd_i,
    input  logic               wreg_i,
    input  mem_pkg::word_t     wdata_i,
    input  logic               exc_taken_i,
    input  mem_pkg::word_t     mem_rdata_i,
    input  logic               mem_rvalid_i,
    input  logic               mem_wready_i,
    output mem_pkg::word_t     mem_addr_o,
    output mem_pkg::sel_t      mem_sel_o,
    output mem_pkg::word_t     mem_wdata_o,
    output logic               mem_we_o,
    output logic               mem_re_o,
    output logic               stall_o,
    result_if.lsu              res
);
    import mem_pkg::*;

    logic [1:0] ofs;
    logic       rd_req;
    logic       wr_req;
    sel_t       sel;
    word_t      st_data;
    logic [7:0] ld_byte;
    logic [15:0] ld_half;
    word_t      ld_data;

    assign ofs = mem_addr_i[1:0];

    // lane picks from the read word
    always_comb
    begin
        case (ofs)
            2'b00:   ld_byte = mem_rdata_i[7:0];
            2'b01:   ld_byte = mem_rdata_i[15:8];
            2'b10:   ld_byte = mem_rdata_i[23:16];
            default: ld_byte = mem_rdata_i[31:24];
        endcase
        ld_half = ofs[1] ? mem_rdata_i[31:16] : mem_rdata_i[15:0];
    end

    always_comb
    begin
        rd_req  = 1'b0;
        wr_req  = 1'b0;
        sel     = 4'b0000;
        st_data = '0;
        ld_data = wdata_i;
        case (aluop_i)
            OP_LB, OP_LBU:
            begin
                rd_req  = 1'b1;
                sel     = 4'b0001 << ofs;
                ld_data = {{24{ld_byte[7] && (aluop_i == OP_LB)}}, ld_byte};
            end
            OP_LH, OP_LHU:
            begin
                // only 0 and 2 are legal halfword offsets
                if (!ofs[0])
                begin
                    rd_req  = 1'b1;
                    sel     = ofs[1] ? 4'b1100 : 4'b0011;
                    ld_data = {{16{ld_half[15] && (aluop_i == OP_LH)}}, ld_half};
                end
            end
            OP_LW:
            begin
                rd_req  = 1'b1;
                sel     = 4'b1111;
                ld_data = mem_rdata_i;
            end
            OP_SB:
            begin
                wr_req  = 1'b1;
                sel     = 4'b0001 << ofs;
                st_data = {4{reg2_i[7:0]}};
            end
            OP_SH:
            begin
                if (!ofs[0])
                begin
                    wr_req  = 1'b1;
                    sel     = ofs[1] ? 4'b1100 : 4'b0011;
                    st_data = {2{reg2_i[15:0]}};
                end
            end
            OP_SW:
            begin
                wr_req  = 1'b1;
                sel     = 4'b1111;
                st_data = reg2_i;
            end
            default:
            begin
                // not a memory op
            end
        endcase
    end

    // an exception cancels both directions
    assign mem_re_o = rd_req && !exc_taken_i;
    assign mem_we_o = wr_req && !exc_taken_i;

    assign mem_addr_o  = (rd_req || wr_req) ? mem_addr_i : '0;
    assign mem_sel_o   = sel;
    assign mem_wdata_o = st_data;

    // hold the pipeline until memory answers
    assign stall_o = (mem_re_o && !mem_rvalid_i) || (mem_we_o && !mem_wready_i);

    assign res.wd    = wd_i;
    assign res.wreg  = wreg_i;
    assign res.wdata = ld_data;

endmodule

`default_nettype wire

// File: src/mem_wb_reg.sv
// memory to writeback register
`timescale 1ns/1ps
`default_nettype none

module mem_wb_reg (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               stall_i,
    result_if.wb               res,
    output mem_pkg::reg_addr_t wb_wd_o,
    output logic               wb_wreg_o,
    output mem_pkg::word_t     wb_wdata_o,
    output mem_pkg::word_t     wb_exc_code_o
);
    import mem_pkg::*;

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            wb_wd_o       <= '0;
            wb_wreg_o     <= 1'b0;
            wb_wdata_o    <= '0;
            wb_exc_code_o <= EXC_NONE;
        end
        else if (stall_i)
        begin
            // bubble while memory is busy
            wb_wd_o       <= '0;
            wb_wreg_o     <= 1'b0;
            wb_wdata_o    <= '0;
            wb_exc_code_o <= EXC_NONE;
        end
        else
        begin
            wb_wd_o       <= res.wd;
            wb_wreg_o     <= res.wreg;
            wb_wdata_o    <= res.wdata;
            wb_exc_code_o <= res.exc_code;
        end
    end

endmodule

`default_nettype wire

// File: src/mem_stage.sv
// memory access stage top
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  logic               clk,
    input  logic               rst_n_i,
    input  mem_pkg::reg_addr_t wd_i,
    input  logic               wreg_i,
    input  mem_pkg::word_t     wdata_i,
    input  mem_pkg::aluop_t    aluop_i,
    input  mem_pkg::word_t     mem_addr_i,
    input  mem_pkg::word_t     reg2_i,
    input  mem_pkg::word_t     excepttype_i,
    input  mem_pkg::word_t     inst_addr_i,
    input  mem_pkg::word_t     cp0_status_i,
    input  mem_pkg::word_t     cp0_cause_i,
    input  mem_pkg::word_t     cp0_epc_i,
    input  logic               wb_cp0_we_i,
    input  mem_pkg::cp0_addr_t wb_cp0_addr_i,
    input  mem_pkg::word_t     wb_cp0_data_i,
    input  mem_pkg::word_t     mem_rdata_i,
    input  logic               mem_rvalid_i,
    input  logic               mem_wready_i,
    output mem_pkg::word_t     mem_addr_o,
    output mem_pkg::sel_t      mem_sel_o,
    output mem_pkg::word_t     mem_wdata_o,
    output logic               mem_we_o,
    output logic               mem_re_o,
    output logic               stall_req_o,
    output mem_pkg::word_t     cp0_epc_o,
    output mem_pkg::reg_addr_t wb_wd_o,
    output logic               wb_wreg_o,
    output mem_pkg::word_t     wb_wdata_o,
    output mem_pkg::word_t     wb_exc_code_o
);
    import mem_pkg::*;

    cp0_view_t cp0_view;
    logic      exc_taken;

    result_if res ();

    cp0_forward u_cp0_forward (
        .wb_cp0_we_i   (wb_cp0_we_i),
        .wb_cp0_addr_i (wb_cp0_addr_i),
        .wb_cp0_data_i (wb_cp0_data_i),
        .cp0_status_i  (cp0_status_i),
        .cp0_cause_i   (cp0_cause_i),
        .cp0_epc_i     (cp0_epc_i),
        .cp0_view_o    (cp0_view)
    );

    assign cp0_epc_o = cp0_view.epc;

    except_resolve u_except_resolve (
        .excepttype_i (excepttype_i),
        .inst_addr_i  (inst_addr_i),
        .cp0_view_i   (cp0_view),
        .exc_taken_o  (exc_taken),
        .res          (res.exc)
    );

    lsu_align u_lsu_align (
        .aluop_i      (aluop_i),
        .mem_addr_i   (mem_addr_i),
        .reg2_i       (reg2_i),
        .wd_i         (wd_i),
        .wreg_i       (wreg_i),
        .wdata_i      (wdata_i),
        .exc_taken_i  (exc_taken),
        .mem_rdata_i  (mem_rdata_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_wready_i (mem_wready_i),
        .mem_addr_o   (mem_addr_o),
        .mem_sel_o    (mem_sel_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_we_o     (mem_we_o),
        .mem_re_o     (mem_re_o),
        .stall_o      (stall_req_o),
        .res          (res.lsu)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_req_o),
        .res           (res.wb),
        .wb_wd_o       (wb_wd_o),
        .wb_wreg_o     (wb_wreg_o),
        .wb_wdata_o    (wb_wdata_o),
        .wb_exc_code_o (wb_exc_code_o)
    );

endmodule

`default_nettype wire

// File: testbench/mem_stage_assertions.sv
// memory bus protocol assertions
`timescale 1ns/1ps
`default_nettype none

module mem_stage_assertions (
    input logic           clk,
    input logic           rst_n_i,
    input logic           mem_we_i,
    input logic           mem_re_i,
    input logic           stall_req_i,
    input mem_pkg::word_t exc_code_i
);
    import mem_pkg::*;

    int fail_cnt = 0;

    // one direction at a time
    assert property (@(posedge clk) disable iff (!rst_n_i) !(mem_we_i && mem_re_i))
    else
    begin
        fail_cnt++;
        $error("read and write requested together");
    end

    assert property (@(posedge clk) disable iff (!rst_n_i) stall_req_i |-> (mem_we_i || mem_re_i))
    else
    begin
        fail_cnt++;
        $error("stall without an active request");
    end

    // a resolved exception kills the access
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (exc_code_i != EXC_NONE) |-> !(mem_we_i || mem_re_i || stall_req_i))
    else
    begin
        fail_cnt++;
        $error("access not cancelled on exception");
    end

endmodule

bind mem_stage mem_stage_assertions u_assertions (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .mem_we_i    (mem_we_o),
    .mem_re_i    (mem_re_o),
    .stall_req_i (stall_req_o),
    .exc_code_i  (res.exc_code)
);

`default_nettype wire

// File: testbench/tb_mem_stage.sv
// memory stage testbench
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;
    import mem_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_VEC    = 19;
    localparam int VEC_W      = 21;
    localparam int WAIT_LIMIT = 16;

    logic      clk;
    logic      rst_n_i;
    reg_addr_t wd_i;
    logic      wreg_i;
    word_t     wdata_i;
    aluop_t    aluop_i;
    word_t     mem_addr_i;
    word_t     reg2_i;
    word_t     excepttype_i;
    word_t     inst_addr_i;
    word_t     cp0_status_i;
    word_t     cp0_cause_i;
    word_t     cp0_epc_i;
    logic      wb_cp0_we_i;
    cp0_addr_t wb_cp0_addr_i;
    word_t     wb_cp0_data_i;
    word_t     mem_rdata_i;
    logic      mem_rvalid_i;
    logic      mem_wready_i;
    word_t     mem_addr_o;
    sel_t      mem_sel_o;
    word_t     mem_wdata_o;
    logic      mem_we_o;
    logic      mem_re_o;
    logic      stall_req_o;
    word_t     cp0_epc_o;
    reg_addr_t wb_wd_o;
    logic      wb_wreg_o;
    word_t     wb_wdata_o;
    word_t     wb_exc_code_o;

    // one vector is VEC_W consecutive words
    word_t stim [0:NUM_VEC*VEC_W-1];
    int    errors;
    int    timeouts;

    mem_stage uut (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .wd_i          (wd_i),
        .wreg_i        (wreg_i),
        .wdata_i       (wdata_i),
        .aluop_i       (aluop_i),
        .mem_addr_i    (mem_addr_i),
        .reg2_i        (reg2_i),
        .excepttype_i  (excepttype_i),
        .inst_addr_i   (inst_addr_i),
        .cp0_status_i  (cp0_status_i),
        .cp0_cause_i   (cp0_cause_i),
        .cp0_epc_i     (cp0_epc_i),
        .wb_cp0_we_i   (wb_cp0_we_i),
        .wb_cp0_addr_i (wb_cp0_addr_i),
        .wb_cp0_data_i (wb_cp0_data_i),
        .mem_rdata_i   (mem_rdata_i),
        .mem_rvalid_i  (mem_rvalid_i),
        .mem_wready_i  (mem_wready_i),
        .mem_addr_o    (mem_addr_o),
        .mem_sel_o     (mem_sel_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_we_o      (mem_we_o),
        .mem_re_o      (mem_re_o),
        .stall_req_o   (stall_req_o),
        .cp0_epc_o     (cp0_epc_o),
        .wb_wd_o       (wb_wd_o),
        .wb_wreg_o     (wb_wreg_o),
        .wb_wdata_o    (wb_wdata_o),
        .wb_exc_code_o (wb_exc_code_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got === exp)
        else
        begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bubble;
        check_value("wb_wreg_o", wb_wreg_o, 0);
        check_value("wb_exc_code_o", wb_exc_code_o, EXC_NONE);
    endtask

    task automatic drive_idle;
        wd_i          = '0;
        wreg_i        = 1'b0;
        wdata_i       = '0;
        aluop_i       = '0;
        mem_addr_i    = '0;
        reg2_i        = '0;
        excepttype_i  = '0;
        inst_addr_i   = '0;
        cp0_status_i  = '0;
        cp0_cause_i   = '0;
        cp0_epc_i     = '0;
        wb_cp0_we_i   = 1'b0;
        wb_cp0_addr_i = '0;
        wb_cp0_data_i = '0;
        mem_rdata_i   = '0;
        mem_rvalid_i  = 1'b0;
        mem_wready_i  = 1'b0;
    endtask

    task automatic run_vector(input int n);
        int    base;
        int    delay;
        int    cnt;
        int    i;
        word_t acc;
        base  = n * VEC_W;
        delay = $urandom % 4;
        acc   = stim[base+17];
        @(negedge clk);
        aluop_i       = stim[base][7:0];
        mem_addr_i    = stim[base+1];
        reg2_i        = stim[base+2];
        wdata_i       = stim[base+3];
        wd_i          = stim[base+4][4:0];
        wreg_i        = stim[base+5][0];
        mem_rdata_i   = stim[base+6];
        cp0_status_i  = stim[base+7];
        cp0_cause_i   = stim[base+8];
        cp0_epc_i     = stim[base+9];
        wb_cp0_we_i   = stim[base+10][0];
        wb_cp0_addr_i = stim[base+11][4:0];
        wb_cp0_data_i = stim[base+12];
        excepttype_i  = stim[base+13];
        inst_addr_i   = stim[base+14];
        // zero delay means memory answers in the request cycle
        mem_rvalid_i  = (acc == 1) && (delay == 0);
        mem_wready_i  = (acc == 2) && (delay == 0);
        #(CLK_PERIOD/4);
        check_value("mem_sel_o", mem_sel_o, stim[base+15]);
        check_value("mem_wdata_o", mem_wdata_o, stim[base+16]);
        check_value("mem_re_o", mem_re_o, acc == 1);
        check_value("mem_we_o", mem_we_o, acc == 2);
        check_value("cp0_epc_o", cp0_epc_o, stim[base+20]);
        check_value("stall_req_o", stall_req_o, (acc != 0) && (delay != 0));
        if (acc != 0)
        begin
            check_value("mem_addr_o", mem_addr_o, stim[base+1]);
            for (i = 1; i <= delay; i++)
            begin
                @(negedge clk);
                check_value("stall_req_o", stall_req_o, 1);
                check_bubble();
                if (i == delay)
                begin
                    mem_rvalid_i = (acc == 1);
                    mem_wready_i = (acc == 2);
                end
            end
            #(CLK_PERIOD/4);
            cnt = 0;
            while (stall_req_o && cnt < WAIT_LIMIT)
            begin
                @(negedge clk);
                #(CLK_PERIOD/4);
                cnt++;
            end
            if (stall_req_o)
            begin
                timeouts++;
                $display("timeout: stall_req_o stayed high in vector %0d", n);
            end
        end
        @(negedge clk);
        check_value("wb_wdata_o", wb_wdata_o, stim[base+18]);
        check_value("wb_exc_code_o", wb_exc_code_o, stim[base+19]);
        check_value("wb_wreg_o", wb_wreg_o, stim[base+5]);
        check_value("wb_wd_o", wb_wd_o, stim[base+4]);
        drive_idle();
    endtask

    initial
    begin
        errors   = 0;
        timeouts = 0;
        void'($urandom(37));
        rst_n_i  = 1'b0;
        drive_idle();
        $readmemh("testbench/mem_stimulus.txt", stim);
        assert (!$isunknown(stim[NUM_VEC*VEC_W-1]))
        else
        begin
            errors++;
            $display("the stimulus file is missing or shorter than expected");
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        #(CLK_PERIOD/4);
        check_value("wb_wreg_o", wb_wreg_o, 0);
        check_value("wb_wd_o", wb_wd_o, 0);
        check_value("wb_wdata_o", wb_wdata_o, 0);
        check_value("wb_exc_code_o", wb_exc_code_o, EXC_NONE);
        check_value("mem_re_o", mem_re_o, 0);
        check_value("mem_we_o", mem_we_o, 0);
        for (int n = 0; n < NUM_VEC; n++)
        begin
            if (timeouts == 0)
                run_vector(n);
        end
        // protocol checker failures count as errors too
        errors = errors + uut.u_assertions.fail_cnt;
        $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/mem_stimulus.txt
// aluop addr reg2 wdata wd wreg rdata status cause epc wb_we wb_addr wb_data exctype inst_addr
// then expected: sel mem_wdata access(0 none 1 read 2 write) wb_wdata exc_code epc
e0 1000 0 11111111 5 1 85f17a92 0 0 0 0 0 0 0 400000 1 0 1 ffffff92 0 0
e0 1001 0 11111111 5 1 85f17a92 0 0 0 0 0 0 0 400000 2 0 1 7a 0 0
e4 1002 0 11111111 5 1 85f17a92 0 0 0 0 0 0 0 400000 4 0 1 f1 0 0
e4 1003 0 11111111 5 1 85f17a92 0 0 0 0 0 0 0 400000 8 0 1 85 0 0
e1 1002 0 11111111 5 1 85f17a92 0 0 0 0 0 0 0 400000 c 0 1 ffff85f1 0 0
e5 1000 0 11111111 5 1 85f17a92 0 0 0 0 0 0 0 400000 3 0 1 7a92 0 0
e3 1000 0 11111111 5 1 85f17a92 0 0 0 0 0 0 0 400000 f 0 1 85f17a92 0 0
e8 1003 aabbcc5e 11111111 5 1 0 0 0 0 0 0 0 0 400000 8 5e5e5e5e 2 11111111 0 0
e9 1002 aabbcc5e 11111111 5 1 0 0 0 0 0 0 0 0 400000 c cc5ecc5e 2 11111111 0 0
eb 1000 aabbcc5e 11111111 5 1 0 0 0 0 0 0 0 0 400000 f aabbcc5e 2 11111111 0 0
eb 1000 aabbcc5e 11111111 5 1 0 0 0 0 0 0 0 4900 400000 f aabbcc5e 0 11111111 8 0
eb 1000 aabbcc5e 11111111 5 1 0 0 0 0 0 0 0 1c00 400000 f aabbcc5e 0 11111111 d 0
eb 1000 aabbcc5e 11111111 5 1 0 0 0 0 0 0 0 8200 400000 f aabbcc5e 0 11111111 9 0
eb 2000 aabbcc5e 11111111 5 1 0 0 0 0 0 0 0 6000 400000 f aabbcc5e 0 11111111 4 0
eb 1000 aabbcc5e 11111111 5 1 0 0 0 0 0 0 0 4900 0 f aabbcc5e 2 11111111 0 0
0 0 0 11111111 5 1 0 0 0 0 1 e bfc00380 0 400000 0 0 0 11111111 0 bfc00380
eb 1000 aabbcc5e 11111111 5 1 0 0 100 0 1 c 101 0 400000 f aabbcc5e 0 11111111 1 0
0 0 0 11111111 5 1 0 301 0 0 1 d 300 0 400000 0 0 0 11111111 1 0
0 0 0 11111111 5 1 0 fc01 0 0 1 d fc00 0 400000 0 0 0 11111111 0 0

// File: mem_stage.f
src/mem_pkg.sv
src/result_if.sv
src/cp0_forward.sv
src/except_resolve.sv
src/lsu_align.sv
src/mem_wb_reg.sv
src/mem_stage.sv
testbench/mem_stage_assertions.sv
testbench/tb_mem_stage.sv

// File: Bender.yml
package:
  name: mem_stage

sources:
  - src/mem_pkg.sv
  - src/result_if.sv
  - src/cp0_forward.sv
  - src/except_resolve.sv
  - src/lsu_align.sv
  - src/mem_wb_reg.sv
  - src/mem_stage.sv
  - target: test
    files:
      - testbench/mem_stage_assertions.sv
      - testbench/tb_mem_stage.sv
